// ==== Bender.yml ====
package:
  name: rmii_port

export_include_dirs:
  - .

sources:
  - rmii_port_pkg.sv
  - frame_stream_if.sv
  - rmii_byte_packager.sv
  - frame_check_sequence.sv
  - frame_buffer.sv
  - rmii_port.sv
  - target: test
    files:
      - rmii_port_tb.sv

// ==== frame_buffer.sv ====
`include "rmii_port_config.svh"

module frame_buffer (
    input  logic                 clock,
    input  logic                 rst_n,
    frame_stream_if.sink         stream,
    input  logic                 frame_good,
    input  logic                 frame_bad,
    output rmii_port_pkg::word_t receive_data,
    output logic                 receive_data_valid,
    input  logic                 receive_data_enable
);
    import rmii_port_pkg::*;

    word_t         memory [`RMII_PORT_BUFFER_DEPTH];

    buffer_count_t commit_ptr;
    buffer_count_t work_ptr;
    buffer_count_t read_ptr;
    buffer_count_t used;
    buffer_addr_t  write_addr;
    buffer_addr_t  read_addr;
    logic          full;
    logic          overflow;
    logic          write_enable;

    // Words held, committed or not
    assign used         = work_ptr - read_ptr;
    assign full         = (used == buffer_count_t'(`RMII_PORT_BUFFER_DEPTH));
    assign write_enable = stream.valid && !overflow && !full;
    assign write_addr   = buffer_addr_t'(work_ptr);
    assign read_addr    = buffer_addr_t'(read_ptr);

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_addr] <= {stream.last, stream.data};
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            commit_ptr <= '0;
            work_ptr   <= '0;
            overflow   <= 1'b0;
        end else begin
            if (write_enable) begin
                work_ptr <= work_ptr + buffer_count_t'(1);
            end
            if (stream.valid && full) begin
                overflow <= 1'b1;
            end

            // Verdict closes the frame
            if (frame_good && !overflow) begin
                commit_ptr <= work_ptr;
            end else if (frame_good || frame_bad) begin
                work_ptr <= commit_ptr;
            end
            if (frame_good || frame_bad) begin
                overflow <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////
    assign receive_data_valid = (read_ptr != commit_ptr);
    assign receive_data       = memory[read_addr];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_ptr <= '0;
        end else if (receive_data_enable && receive_data_valid) begin
            read_ptr <= read_ptr + buffer_count_t'(1);
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        used <= buffer_count_t'(`RMII_PORT_BUFFER_DEPTH));

endmodule

// ==== frame_check_sequence.sv ====
`include "rmii_port_config.svh"

module frame_check_sequence (
    input  logic         clock,
    input  logic         rst_n,
    frame_stream_if.sink stream,
    output logic         frame_good,
    output logic         frame_bad
);
    import rmii_port_pkg::*;

    crc_t crc;
    crc_t crc_update;

    // One byte of reflected CRC-32
    function automatic crc_t crc_next(crc_t crc_in, byte_t data);
        crc_t c;
        c = crc_in ^ crc_t'(data);
        for (int i = 0; i < `RMII_PORT_BYTE_WIDTH; i++) begin
            c = c[0] ? ((c >> 1) ^ `RMII_PORT_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_update = crc_next(crc, stream.data);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            crc        <= '1;
            frame_good <= 1'b0;
            frame_bad  <= 1'b0;
        end else begin
            frame_good <= 1'b0;
            frame_bad  <= 1'b0;
            if (stream.valid) begin
                if (stream.last) begin
                    // Preset again for the next frame
                    crc <= '1;
                    if (crc_update == `RMII_PORT_CRC_RESIDUE && !stream.error) begin
                        frame_good <= 1'b1;
                    end else begin
                        frame_bad <= 1'b1;
                    end
                end else begin
                    crc <= crc_update;
                end
            end
        end
    end

    // One verdict, right after the closing byte
    assert property (@(posedge clock) disable iff (!rst_n)
        frame_good || frame_bad |->
            $onehot({frame_good, frame_bad}) && $past(stream.valid && stream.last));

endmodule

// ==== frame_stream_if.sv ====
interface frame_stream_if;
    import rmii_port_pkg::*;

    byte_t data;
    logic  last;
    logic  error;
    logic  valid;

    modport source (
        output data,
        output last,
        output error,
        output valid
    );

    modport sink (
        input data,
        input last,
        input error,
        input valid
    );

endinterface

// ==== rmii_byte_packager.sv ====
`include "rmii_port_config.svh"

module rmii_byte_packager (
    input  logic                  clock,
    input  logic                  rst_n,
    input  rmii_port_pkg::dibit_t rmii_receive_data,
    input  logic                  rmii_receive_data_enable,
    input  logic                  rmii_receive_data_error,
    frame_stream_if.source        stream
);
    import rmii_port_pkg::*;

    packager_state_t state;
    byte_t           shift;
    byte_t           next_shift;
    byte_t           reserve;
    logic            have_reserve;
    logic [1:0]      dibit_count;
    logic            error_seen;
    logic            byte_done;

    // Dibits arrive least significant first
    assign next_shift = {rmii_receive_data,
                         shift[`RMII_PORT_BYTE_WIDTH-1:`RMII_PORT_DIBIT_WIDTH]};
    assign byte_done  = (state == FRAME) && rmii_receive_data_enable && (dibit_count == 2'd3);

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= HUNT;
            have_reserve <= 1'b0;
            dibit_count  <= 2'd0;
            error_seen   <= 1'b0;
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
            stream.error <= 1'b0;
        end else begin
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
            stream.error <= 1'b0;
            case (state)
                HUNT: begin
                    if (rmii_receive_data_enable && next_shift == `RMII_PORT_SFD) begin
                        state        <= FRAME;
                        dibit_count  <= 2'd0;
                        have_reserve <= 1'b0;
                        error_seen   <= 1'b0;
                    end
                end
                FRAME: begin
                    if (!rmii_receive_data_enable) begin
                        // Carrier gone, the held byte is the last one
                        state        <= DRAIN;
                        stream.valid <= have_reserve;
                        stream.last  <= 1'b1;
                        stream.error <= error_seen;
                    end else begin
                        dibit_count <= dibit_count + 2'd1;
                        error_seen  <= error_seen | rmii_receive_data_error;
                        if (byte_done) begin
                            stream.valid <= have_reserve;
                            have_reserve <= 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    state <= HUNT;
                end
                default: begin
                    state <= HUNT;
                end
            endcase
        end
    end

    // Byte assembly
    always_ff @(posedge clock) begin
        if (rmii_receive_data_enable) begin
            shift <= next_shift;
        end
        if (byte_done) begin
            reserve <= next_shift;
        end
        stream.data <= reserve;
    end

    // Back to back bytes only when the last byte follows a full one
    assert property (@(posedge clock) disable iff (!rst_n)
        stream.valid && $past(stream.valid) |-> state == DRAIN);

endmodule

// ==== rmii_port.f ====
+incdir+.
rmii_port_pkg.sv
frame_stream_if.sv
rmii_byte_packager.sv
frame_check_sequence.sv
frame_buffer.sv
rmii_port.sv
rmii_port_tb.sv

// ==== rmii_port.sv ====
module rmii_port (
    input  logic                  clock,
    input  logic                  rst_n,
    input  rmii_port_pkg::dibit_t rmii_receive_data,
    input  logic                  rmii_receive_data_enable,
    input  logic                  rmii_receive_data_error,
    output rmii_port_pkg::word_t  receive_data,
    output logic                  receive_data_valid,
    input  logic                  receive_data_enable
);

    logic frame_good;
    logic frame_bad;

    frame_stream_if stream ();

    rmii_byte_packager rmii_byte_packager (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .stream                   (stream.source)
    );

    frame_check_sequence frame_check_sequence (
        .clock      (clock),
        .rst_n      (rst_n),
        .stream     (stream.sink),
        .frame_good (frame_good),
        .frame_bad  (frame_bad)
    );

    // Holds frames until the verdict
    frame_buffer frame_buffer (
        .clock               (clock),
        .rst_n               (rst_n),
        .stream              (stream.sink),
        .frame_good          (frame_good),
        .frame_bad           (frame_bad),
        .receive_data        (receive_data),
        .receive_data_valid  (receive_data_valid),
        .receive_data_enable (receive_data_enable)
    );

endmodule

// ==== rmii_port_config.svh ====
`ifndef RMII_PORT_CONFIG_SVH
`define RMII_PORT_CONFIG_SVH

// RMII line and frame widths
`define RMII_PORT_DIBIT_WIDTH 2
`define RMII_PORT_BYTE_WIDTH 8
`define RMII_PORT_WORD_WIDTH 9

// Frame buffer capacity in words
`define RMII_PORT_BUFFER_DEPTH 256

// Start of frame delimiter
`define RMII_PORT_SFD 8'hD5

// Reflected CRC-32
`define RMII_PORT_CRC_WIDTH 32
`define RMII_PORT_CRC_POLY 32'hEDB88320
`define RMII_PORT_CRC_RESIDUE 32'hDEBB20E3

`endif

// ==== rmii_port_pkg.sv ====
`include "rmii_port_config.svh"

package rmii_port_pkg;

    localparam int BUFFER_ADDR_WIDTH = $clog2(`RMII_PORT_BUFFER_DEPTH);

    typedef logic [`RMII_PORT_DIBIT_WIDTH-1:0] dibit_t;
    typedef logic [`RMII_PORT_BYTE_WIDTH-1:0]  byte_t;

    // Top bit is the last flag
    typedef logic [`RMII_PORT_WORD_WIDTH-1:0]  word_t;

    typedef logic [`RMII_PORT_CRC_WIDTH-1:0]   crc_t;

    typedef logic [BUFFER_ADDR_WIDTH-1:0]      buffer_addr_t;
    // Extra bit tells full from empty
    typedef logic [BUFFER_ADDR_WIDTH:0]        buffer_count_t;

    typedef enum logic [1:0] {
        HUNT,
        FRAME,
        DRAIN
    } packager_state_t;

endpackage

// ==== rmii_port_tb.sv ====
`include "rmii_port_config.svh"

module rmii_port_tb;
    import rmii_port_pkg::*;

    logic          clock;
    logic          rst_n;
    dibit_t        rmii_receive_data;
    logic          rmii_receive_data_enable;
    logic          rmii_receive_data_error;
    word_t         receive_data;
    logic          receive_data_valid;
    logic          receive_data_enable;

    // Reference model state
    byte_t         frame [$];
    word_t         expected [$];
    buffer_count_t expected_count;
    buffer_count_t received_count;
    logic          reader_on;

    int word_errors  = 0;
    int count_errors = 0;
    int other_errors = 0;
    int timeouts     = 0;

    rmii_port UUT (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .receive_data             (receive_data),
        .receive_data_valid       (receive_data_valid),
        .receive_data_enable      (receive_data_enable)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Checks and run control
    ////////////////////////////////////////////////////////////
    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            word_errors++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input buffer_count_t got, input buffer_count_t exp,
                               input string what);
        if (got !== exp) begin
            count_errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_and_finish();
        int total;
        total = word_errors + count_errors + other_errors + timeouts;
        $display("errors: %0d word, %0d count, %0d other, %0d timeout",
                 word_errors, count_errors, other_errors, timeouts);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("Timed out at %0t while waiting for %s", $time, what);
        report_and_finish();
    endtask

    ////////////////////////////////////////////////////////////
    // Frame model and stimulus
    ////////////////////////////////////////////////////////////
    // Bit serial CRC-32 taken LSB first and inverted for the FCS
    function automatic crc_t frame_crc();
        crc_t crc;
        logic feedback;
        crc = '1;
        foreach (frame[i]) begin
            for (int k = 0; k < `RMII_PORT_BYTE_WIDTH; k++) begin
                feedback = crc[0] ^ frame[i][k];
                crc = crc >> 1;
                if (feedback) begin
                    crc = crc ^ `RMII_PORT_CRC_POLY;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic build_frame();
        crc_t fcs;
        int   len;
        len = 8 + $urandom % 33;
        frame = {};
        repeat (len) begin
            frame.push_back(byte_t'($urandom));
        end
        fcs = frame_crc();
        for (int k = 0; k < 4; k++) begin
            frame.push_back(fcs[8*k +: 8]);
        end
    endtask

    task automatic expect_frame();
        foreach (frame[i]) begin
            expected.push_back(word_t'({(i == frame.size() - 1), frame[i]}));
        end
        expected_count = expected_count + buffer_count_t'(frame.size());
    endtask

    // Preamble, optional delimiter, then the frame two bits per clock
    task automatic send_frame(input bit with_sfd, input int corrupt_at, input int error_at);
        byte_t line [$];
        byte_t b;
        int    body_start;
        repeat (7) begin
            line.push_back(8'h55);
        end
        if (with_sfd) begin
            line.push_back(`RMII_PORT_SFD);
        end
        body_start = line.size();
        foreach (frame[i]) begin
            b = frame[i];
            if (i == corrupt_at) begin
                b = b ^ 8'h10;
            end
            line.push_back(b);
        end
        foreach (line[i]) begin
            for (int d = 0; d < 4; d++) begin
                @(posedge clock);
                rmii_receive_data        <= line[i][2*d +: 2];
                rmii_receive_data_enable <= 1'b1;
                rmii_receive_data_error  <= (error_at >= 0) &&
                                            ((i - body_start) * 4 + d == error_at);
            end
        end
        @(posedge clock);
        rmii_receive_data_enable <= 1'b0;
        rmii_receive_data_error  <= 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clock);
    endtask

    task automatic frame_gap();
        idle(4 + $urandom % 8);
    endtask

    task automatic send_good();
        build_frame();
        expect_frame();
        send_frame(1'b1, -1, -1);
        frame_gap();
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            if (receive_data_valid) begin
                other_errors++;
                $display("error at %0t: receive_data_valid high with no frame sent", $time);
            end
        end
    endtask

    task automatic set_reader(input logic on);
        @(negedge clock);
        reader_on = on;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (expected.size() != 0) begin
            @(negedge clock);
            n++;
            if (n > limit) begin
                timed_out("the expected words to be read");
            end
        end
    endtask

    task automatic end_phase(input string name);
        wait_drained(2000);
        idle(8);
        @(negedge clock);
        check_count(received_count, expected_count, name);
        received_count = '0;
        expected_count = '0;
    endtask

    // Reads at random and checks each consumed word
    initial begin : reader
        receive_data_enable = 1'b0;
        forever begin
            @(posedge clock);
            if (rst_n && receive_data_enable && receive_data_valid) begin
                received_count = received_count + buffer_count_t'(1);
                if (expected.size() == 0) begin
                    other_errors++;
                    $display("error at %0t: word %h read with no frame expected",
                             $time, receive_data);
                end else begin
                    check_word(receive_data, expected.pop_front(), "received word");
                end
            end
            receive_data_enable <= reader_on && ($urandom % 3 != 0);
        end
    end

    initial begin : main
        int stored;
        int latency;
        void'($urandom(32'hbe3e_4551));
        rst_n                    = 1'b0;
        rmii_receive_data        = '0;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
        reader_on                = 1'b1;
        expected_count           = '0;
        received_count           = '0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        // Idle line and then a good frame with no delimiter
        idle_check(20);
        build_frame();
        send_frame(1'b0, -1, -1);
        idle_check(20);
        end_phase("words after idle");

        repeat (6) send_good();
        end_phase("words of good frames");

        // Corrupted byte under the FCS of the original
        send_good();
        build_frame();
        send_frame(1'b1, $urandom % (frame.size() - 4), -1);
        frame_gap();
        send_good();
        end_phase("words around corrupted frame");

        send_good();
        build_frame();
        send_frame(1'b1, -1, $urandom % (frame.size() * 4));
        frame_gap();
        send_good();
        end_phase("words around receive error");

        // Reader stalled until all frames are in
        set_reader(1'b0);
        idle(4);
        stored = 0;
        repeat (12) begin
            build_frame();
            if (frame.size() <= `RMII_PORT_BUFFER_DEPTH - stored) begin
                expect_frame();
                stored += frame.size();
            end
            send_frame(1'b1, -1, -1);
            frame_gap();
        end
        set_reader(1'b1);
        end_phase("words after overflow");

        set_reader(1'b0);
        idle(4);
        build_frame();
        expect_frame();
        send_frame(1'b1, -1, -1);
        latency = 0;
        @(negedge clock);
        while (!receive_data_valid) begin
            @(negedge clock);
            latency++;
            if (latency > 20) begin
                timed_out("the first word of a frame");
            end
        end
        if (latency > 3) begin
            other_errors++;
            $display("error at %0t: first word valid %0d cycles after carrier drop, limit 3",
                     $time, latency);
        end
        set_reader(1'b1);
        end_phase("words of latency frame");

        report_and_finish();
    end

endmodule
